//--- compile.f
verilog/rdma_rd_pkg.sv
verilog/meta_fifo.sv
verilog/rd_cmd_router.sv
verilog/rd_beat_counter.sv
verilog/rd_mux_fsm.sv
verilog/rd_data_select.sv
verilog/rdma_rd_mux.sv
test/tb_rdma_rd_mux.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RDMA read mux testbench with Verilator

verilator --binary --timing --top-module tb_rdma_rd_mux -f compile.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_rdma_rd_mux > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

//--- test/tb_rdma_rd_mux.sv
// RDMA read mux testbench
// Directed tests on the command port, the region request queues and
// the merged read data stream. Region models hold queues of beats;
// one monitor checks queue pushes and output beats against
// expectations built for each request.

`timescale 1ns/1ps
`default_nettype none

module tb_rdma_rd_mux;

  localparam int NR      = rdma_rd_pkg::N_REGIONS;
  localparam int DW      = rdma_rd_pkg::DATA_BITS;
  localparam int TIMEOUT = 2000;

  logic                        aclk;
  logic                        aresetn;
  logic                        req_valid;
  logic                        req_ready;
  rdma_rd_pkg::req_t           req_data;
  logic [NR-1:0]               m_req_valid;
  logic [NR-1:0]               m_req_ready;
  rdma_rd_pkg::req_t [NR-1:0]  m_req_data;
  logic [NR-1:0]               rd_tvalid;
  logic [NR-1:0]               rd_tready;
  logic [NR-1:0][DW-1:0]       rd_tdata;
  logic [NR-1:0]               rd_tlast;
  logic                        out_tvalid;
  logic                        out_tready;
  logic [DW-1:0]               out_tdata;
  logic                        out_tlast;

  // Beats as {last, data}; region id sits in data[57:56]
  logic [DW:0]        reg_q [NR][$];
  logic [DW:0]        beat_q [$];
  rdma_rd_pkg::req_t  req_q [NR][$];
  int                 errors;
  int                 beats_seen;
  int                 region_beats [NR];
  int                 tests_run;
  int                 tests_failed;
  int                 tag;
  bit                 stall_en;

  rdma_rd_mux i_dut (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_data    (req_data),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_data  (m_req_data),
    .rd_tvalid   (rd_tvalid),
    .rd_tready   (rd_tready),
    .rd_tdata    (rd_tdata),
    .rd_tlast    (rd_tlast),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .out_tdata   (out_tdata),
    .out_tlast   (out_tlast)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_req(input string name, input rdma_rd_pkg::req_t exp,
                           input rdma_rd_pkg::req_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_beat(input logic [DW-1:0] exp_data, input logic exp_last,
                            input logic [DW-1:0] act_data, input logic act_last);
    if (act_data !== exp_data) begin
      $display("MISMATCH out_tdata: expected %h, got %h", exp_data, act_data);
      errors++;
    end
    if (act_last !== exp_last) begin
      $display("MISMATCH out_tlast: expected %h, got %h", exp_last, act_last);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  // 8 bytes per beat, partial tail counts as a whole beat
  function automatic int beats_for(input int len);
    return (len + 7) / 8;
  endfunction

  // ------------------------------
  // Region models and monitor
  // ------------------------------
  // Models present their head beat from the falling edge
  initial begin
    rd_tvalid  = '0;
    rd_tdata   = '0;
    rd_tlast   = '0;
    out_tready = 1'b1;
    forever begin
      @(negedge aclk);
      for (int r = 0; r < NR; r++) begin
        if (reg_q[r].size() > 0) begin
          rd_tvalid[r] = 1'b1;
          rd_tdata[r]  = reg_q[r][0][DW-1:0];
          rd_tlast[r]  = reg_q[r][0][DW];
        end else begin
          rd_tvalid[r] = 1'b0;
        end
      end
      // Stall roughly one cycle in four
      out_tready = stall_en ? (($urandom() % 4) != 0) : 1'b1;
    end
  end

  initial begin
    logic [DW:0]       exp_beat;
    rdma_rd_pkg::req_t exp_req;
    int                sel;
    forever begin
      @(posedge aclk);
      if (aresetn) begin
        // Only the region owning the head beat may see tready
        sel = (beat_q.size() > 0) ? int'(beat_q[0][57:56]) : -1;
        for (int r = 0; r < NR; r++) begin
          if (rd_tready[r] && r != sel) begin
            $display("ERROR: rd_tready high on unselected region %0d", r);
            errors++;
          end
          if (rd_tvalid[r] && rd_tready[r]) begin
            reg_q[r].delete(0);
          end
          if (m_req_valid[r] && req_q[r].size() == 0) begin
            $display("ERROR: region %0d queue valid without a pending host request", r);
            errors++;
          end else if (m_req_valid[r] && m_req_ready[r]) begin
            exp_req = req_q[r].pop_front();
            check_req($sformatf("m_req_data[%0d]", r), exp_req, m_req_data[r]);
          end
        end
        if (out_tvalid && out_tready) begin
          if (beat_q.size() == 0) begin
            $display("ERROR: output beat %h arrived with none expected", out_tdata);
            errors++;
          end else begin
            exp_beat = beat_q.pop_front();
            check_beat(exp_beat[DW-1:0], exp_beat[DW], out_tdata, out_tlast);
          end
          beats_seen++;
          region_beats[int'(out_tdata[57:56])]++;
        end
      end
    end
  end

  // ------------------------------
  // Request helpers
  // ------------------------------
  // Loads region data and expectations, builds the request
  task automatic prepare_req(input logic [1:0] vfid, input logic host, input int len,
                             output rdma_rd_pkg::req_t req);
    int          n;
    logic [63:0] d;
    n = beats_for(len);
    for (int b = 0; b < n; b++) begin
      d = {8'(vfid), 8'(tag), 16'(b), $urandom()};
      reg_q[vfid].push_back({(b == n - 1), d});
      beat_q.push_back({(b == n - 1), d});
    end
    req.vfid  = vfid;
    req.host  = host;
    req.len   = 16'(len);
    req.vaddr = $urandom();
    if (host) begin
      req_q[vfid].push_back(req);
    end
    tag++;
  endtask

  // Leaves req_valid high; the caller drops it or sends again
  task automatic send_req(input rdma_rd_pkg::req_t req);
    int n;
    n = 0;
    @(negedge aclk);
    req_valid = 1'b1;
    req_data  = req;
    @(posedge aclk);
    while (!req_ready && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
    end
    if (!req_ready) begin
      $display("ERROR: timeout waiting for req_ready");
      errors++;
    end
  endtask

  task automatic drop_req();
    @(negedge aclk);
    req_valid = 1'b0;
  endtask

  function automatic bit work_pending();
    bit busy;
    busy = (beat_q.size() != 0);
    for (int r = 0; r < NR; r++) begin
      busy |= (req_q[r].size() != 0);
    end
    return busy;
  endfunction

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    while (work_pending() && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
    end
    if (work_pending()) begin
      $display("ERROR: timeout waiting for %s to complete", what);
      errors++;
      beat_q.delete();
      for (int r = 0; r < NR; r++) begin
        reg_q[r].delete();
        req_q[r].delete();
      end
    end
    @(negedge aclk);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
    end
    $display("%s: %0d errors", name, errors - err_start);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic host_forwarding();
    int                e;
    int                b1;
    rdma_rd_pkg::req_t r;
    e  = errors;
    b1 = region_beats[1];
    prepare_req(2'd1, 1'b1, 32, r);
    send_req(r);
    drop_req();
    wait_drained("host request to region 1");
    check_count("region 1 beats", beats_for(32), region_beats[1] - b1);
    finish_test("host_forwarding", e);
  endtask

  task automatic non_host_forwarding();
    int                e;
    int                b2;
    rdma_rd_pkg::req_t r;
    e  = errors;
    b2 = region_beats[2];
    prepare_req(2'd2, 1'b0, 16, r);
    send_req(r);
    drop_req();
    wait_drained("non-host request to region 2");
    check_count("region 2 beats", beats_for(16), region_beats[2] - b2);
    finish_test("non_host_forwarding", e);
  endtask

  task automatic request_ordering();
    int                e;
    rdma_rd_pkg::req_t r [3];
    e = errors;
    // All data in place before any request
    prepare_req(2'd2, 1'b1, 24, r[0]);
    prepare_req(2'd0, 1'b1, 40, r[1]);
    prepare_req(2'd3, 1'b1, 8, r[2]);
    repeat (2) @(negedge aclk);
    for (int i = 0; i < 3; i++) begin
      send_req(r[i]);
    end
    drop_req();
    wait_drained("ordered requests");
    finish_test("request_ordering", e);
  endtask

  task automatic length_rounding();
    int                e;
    int                b0;
    int                b3;
    rdma_rd_pkg::req_t r;
    e  = errors;
    b0 = region_beats[0];
    b3 = region_beats[3];
    prepare_req(2'd0, 1'b1, 20, r);
    send_req(r);
    prepare_req(2'd3, 1'b0, 8, r);
    send_req(r);
    drop_req();
    wait_drained("rounding requests");
    check_count("region 0 beats", beats_for(20), region_beats[0] - b0);
    check_count("region 3 beats", beats_for(8), region_beats[3] - b3);
    finish_test("length_rounding", e);
  endtask

  task automatic stalled_batch();
    int                e;
    int                start;
    int                total;
    int                len;
    rdma_rd_pkg::req_t r;
    e        = errors;
    start    = beats_seen;
    total    = 0;
    stall_en = 1'b1;
    for (int i = 0; i < 8; i++) begin
      len = int'($urandom_range(64, 1));
      prepare_req(2'($urandom_range(3)), 1'($urandom_range(1)), len, r);
      send_req(r);
      total += beats_for(len);
    end
    drop_req();
    wait_drained("stalled batch");
    stall_en = 1'b0;
    check_count("total beats", total, beats_seen - start);
    finish_test("stalled_batch", e);
  endtask

  task automatic region_queue_full();
    int                e;
    int                n;
    bit                saw_low;
    bit                accepted;
    rdma_rd_pkg::req_t r;
    e        = errors;
    saw_low  = 1'b0;
    accepted = 1'b0;
    @(negedge aclk);
    m_req_ready[0] = 1'b0;
    // Four fill the region 0 queue
    for (int i = 0; i < 4; i++) begin
      prepare_req(2'd0, 1'b1, 8, r);
      send_req(r);
    end
    prepare_req(2'd0, 1'b1, 8, r);
    @(negedge aclk);
    req_data = r;
    for (int i = 0; i < 4 && !accepted; i++) begin
      @(posedge aclk);
      if (req_ready) begin
        accepted = 1'b1;
      end else begin
        saw_low = 1'b1;
      end
    end
    if (!saw_low) begin
      $display("ERROR: req_ready stayed high with region 0 queue full");
      errors++;
    end
    @(negedge aclk);
    m_req_ready[0] = 1'b1;
    n = 0;
    while (!accepted && n < TIMEOUT) begin
      @(posedge aclk);
      accepted = req_ready;
      n++;
    end
    if (!accepted) begin
      $display("ERROR: fifth request never accepted after queue release");
      errors++;
    end
    drop_req();
    wait_drained("region 0 queue");
    finish_test("region_queue_full", e);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    errors       = 0;
    beats_seen   = 0;
    tests_run    = 0;
    tests_failed = 0;
    tag          = 0;
    stall_en     = 1'b0;
    region_beats = '{default: 0};
    void'($urandom(32'h582b9332));
    aresetn     = 1'b0;
    req_valid   = 1'b0;
    req_data    = '0;
    m_req_ready = '1;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
    repeat (2) @(negedge aclk);

    host_forwarding();
    non_host_forwarding();
    request_ordering();
    length_rounding();
    stalled_batch();
    region_queue_full();

    $display("tests run %0d, tests failed %0d, errors %0d, beats %0d",
             tests_run, tests_failed, errors, beats_seen);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Hard limit on simulated time
  initial begin
    #5000000;
    $display("ERROR: simulation time limit reached");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/meta_fifo.sv
// Synchronous metadata FIFO
// Circular buffer with separate read and write pointers and an
// occupancy count. Payload type is a parameter so the same block
// holds region requests and sequence entries.
// A pushed entry is visible on the output one cycle later.

`timescale 1ns/1ps
`default_nettype none

module meta_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  wire  aclk,
  input  wire  aresetn,
  // Write side
  input  wire  in_valid,
  output logic in_ready,
  input  wire  T in_data,
  // Read side
  output logic out_valid,
  input  wire  out_ready,
  output T     out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Full only blocks the writer
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  // Head entry straight from storage
  assign out_data = mem[rd_ptr];

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/rd_beat_counter.sv
// Read beat counter
// Loads the number of beats minus one for a request and counts down
// on every output beat. Flags the beat that ends the request.

`timescale 1ns/1ps
`default_nettype none

module rd_beat_counter (
  input  wire                              aclk,
  input  wire                              aresetn,
  // Load strobe with the byte length of the next request
  input  wire                              load,
  input  wire [rdma_rd_pkg::LEN_BITS-1:0]  load_len,
  // One pulse per output transfer
  input  wire                              beat_fire,
  output logic                             last_beat
);

  // Remaining beats minus one
  logic [rdma_rd_pkg::CNT_BITS-1:0] cnt;

  // Final beat when nothing is left after this one
  assign last_beat = (cnt == '0) & beat_fire;

  // ------------------------------
  // Count register
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt <= '0;
    end else if (load) begin
      // Load wins over the last-beat decrement of the previous request
      cnt <= rdma_rd_pkg::beats_minus_one(load_len);
    end else if (beat_fire && (cnt != '0)) begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rd_cmd_router.sv
// Read command router
// Accepts requests from the command port. Every request leaves a
// sequence entry; host requests are also pushed to the queue of the
// region named by vfid. Both pushes happen in the accept cycle, and
// the request waits while either target is full.

`timescale 1ns/1ps
`default_nettype none

module rd_cmd_router (
  // Command port
  input  wire                                 req_valid,
  output logic                                req_ready,
  input  wire rdma_rd_pkg::req_t              req_data,
  // Region request queues, one push per region
  output logic [rdma_rd_pkg::N_REGIONS-1:0]   rq_valid,
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0]   rq_ready,
  output rdma_rd_pkg::req_t                   rq_data,
  // Sequence queue
  output logic                                seq_valid,
  input  wire                                 seq_ready,
  output rdma_rd_pkg::seq_t                   seq_data
);

  logic                                 host;
  logic [rdma_rd_pkg::REGION_BITS-1:0]  vfid;
  logic                                 region_ok;
  logic                                 accept;

  // ------------------------------
  // Decode
  // ------------------------------
  assign host = req_data.host;
  assign vfid = req_data.vfid;

  // Target region only matters for host requests
  assign region_ok = ~host | rq_ready[vfid];

  // Joint acceptance, combinational on queue state
  assign req_ready = seq_ready & region_ok;
  assign accept    = req_valid & req_ready;

  // ------------------------------
  // Sequence entry
  // ------------------------------
  // Written for host and non-host requests alike
  assign seq_valid     = accept;
  assign seq_data.vfid = vfid;
  assign seq_data.len  = req_data.len;

  // ------------------------------
  // Region push
  // ------------------------------
  // Request travels unchanged
  assign rq_data = req_data;

  // At most one region raised, and only for host requests
  always_comb begin
    rq_valid = '0;
    for (int i = 0; i < rdma_rd_pkg::N_REGIONS; i++) begin
      if (vfid == rdma_rd_pkg::REGION_BITS'(i)) begin
        rq_valid[i] = accept & host;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/rd_data_select.sv
// Read data selector
// Combinational crossbar from the region data streams to the single
// output stream. Only the selected region sees tready; all others
// are held off. tlast passes through from the source.

`timescale 1ns/1ps
`default_nettype none

module rd_data_select (
  input  wire                                                       active,
  input  wire  [rdma_rd_pkg::REGION_BITS-1:0]                       sel_vfid,
  // Region streams
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0]                         rd_tvalid,
  output logic [rdma_rd_pkg::N_REGIONS-1:0]                         rd_tready,
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0][rdma_rd_pkg::DATA_BITS-1:0] rd_tdata,
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0]                         rd_tlast,
  // Output stream
  output logic                                                      out_tvalid,
  input  wire                                                       out_tready,
  output logic [rdma_rd_pkg::DATA_BITS-1:0]                         out_tdata,
  output logic                                                      out_tlast,
  // Output transfer strobe
  output logic                                                      beat_fire
);

  // Valid only while a request is being served
  assign out_tvalid = active & rd_tvalid[sel_vfid];
  assign out_tdata  = rd_tdata[sel_vfid];
  assign out_tlast  = rd_tlast[sel_vfid];
  assign beat_fire  = out_tvalid & out_tready;

  // Back-pressure reaches the selected region only
  always_comb begin
    for (int i = 0; i < rdma_rd_pkg::N_REGIONS; i++) begin
      rd_tready[i] = active & out_tready &
                     (sel_vfid == rdma_rd_pkg::REGION_BITS'(i));
    end
  end

endmodule

`default_nettype wire

//--- verilog/rd_mux_fsm.sv
// Read data mux controller
// Pops sequence entries in order and holds the region whose data is
// being forwarded. Pops immediately when idle, and on the last beat
// of a request when the next entry is already waiting, so successive
// requests run without gaps.

`timescale 1ns/1ps
`default_nettype none

module rd_mux_fsm (
  input  wire                                   aclk,
  input  wire                                   aresetn,
  // Sequence queue output
  input  wire                                   seq_valid,
  output logic                                  seq_ready,
  input  wire rdma_rd_pkg::seq_t                seq_data,
  // End of current request
  input  wire                                   last_beat,
  // Counter load, region select
  output logic                                  load,
  output logic                                  active,
  output logic [rdma_rd_pkg::REGION_BITS-1:0]   sel_vfid
);

  typedef enum logic {
    ST_IDLE,
    ST_MUX
  } state_t;

  state_t state;
  state_t state_nxt;

  // Ready when idle or finishing the current request
  assign seq_ready = (state == ST_IDLE) | last_beat;
  assign load      = seq_valid & seq_ready;
  assign active    = (state == ST_MUX);

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (seq_valid) state_nxt = ST_MUX;
      end
      ST_MUX: begin
        // Stay if a successor is popped on the last beat
        if (last_beat && !seq_valid) state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= ST_IDLE;
      sel_vfid <= '0;
    end else begin
      state <= state_nxt;
      // Region latched with the pop
      if (load) sel_vfid <= seq_data.vfid;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rdma_rd_mux.sv
// RDMA read mux top level
// Routes read requests to per-region request queues and records
// every request in an in-order sequence queue. The controller,
// beat counter and selector then drain the region data streams
// onto one output stream in request order.

`timescale 1ns/1ps
`default_nettype none

module rdma_rd_mux (
  input  wire                                                       aclk,
  input  wire                                                       aresetn,
  // Command port
  input  wire                                                       req_valid,
  output logic                                                      req_ready,
  input  wire rdma_rd_pkg::req_t                                    req_data,
  // Region request queues
  output logic [rdma_rd_pkg::N_REGIONS-1:0]                         m_req_valid,
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0]                         m_req_ready,
  output rdma_rd_pkg::req_t [rdma_rd_pkg::N_REGIONS-1:0]            m_req_data,
  // Region read data
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0]                         rd_tvalid,
  output logic [rdma_rd_pkg::N_REGIONS-1:0]                         rd_tready,
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0][rdma_rd_pkg::DATA_BITS-1:0] rd_tdata,
  input  wire  [rdma_rd_pkg::N_REGIONS-1:0]                         rd_tlast,
  // Merged output
  output logic                                                      out_tvalid,
  input  wire                                                       out_tready,
  output logic [rdma_rd_pkg::DATA_BITS-1:0]                         out_tdata,
  output logic                                                      out_tlast
);

  // Router to region queues
  logic [rdma_rd_pkg::N_REGIONS-1:0]    rq_valid;
  logic [rdma_rd_pkg::N_REGIONS-1:0]    rq_ready;
  rdma_rd_pkg::req_t                    rq_data;
  // Router to sequence queue
  logic                                 seq_in_valid;
  logic                                 seq_in_ready;
  rdma_rd_pkg::seq_t                    seq_in_data;
  // Sequence queue to controller
  logic                                 seq_out_valid;
  logic                                 seq_out_ready;
  rdma_rd_pkg::seq_t                    seq_out_data;
  // Controller, counter, selector
  logic                                 load;
  logic                                 active;
  logic [rdma_rd_pkg::REGION_BITS-1:0]  sel_vfid;
  logic                                 beat_fire;
  logic                                 last_beat;

  // ------------------------------
  // Command side
  // ------------------------------
  rd_cmd_router i_router (
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_data  (req_data),
    .rq_valid  (rq_valid),
    .rq_ready  (rq_ready),
    .rq_data   (rq_data),
    .seq_valid (seq_in_valid),
    .seq_ready (seq_in_ready),
    .seq_data  (seq_in_data)
  );

  // One request queue per region
  for (genvar g = 0; g < rdma_rd_pkg::N_REGIONS; g++) begin : g_req_que
    meta_fifo #(
      .T     (rdma_rd_pkg::req_t),
      .DEPTH (rdma_rd_pkg::REQ_QUEUE_DEPTH)
    ) i_req_que (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (rq_valid[g]),
      .in_ready  (rq_ready[g]),
      .in_data   (rq_data),
      .out_valid (m_req_valid[g]),
      .out_ready (m_req_ready[g]),
      .out_data  (m_req_data[g])
    );
  end

  // Outstanding requests in arrival order
  meta_fifo #(
    .T     (rdma_rd_pkg::seq_t),
    .DEPTH (rdma_rd_pkg::N_OUTSTANDING)
  ) i_seq_que (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (seq_in_valid),
    .in_ready  (seq_in_ready),
    .in_data   (seq_in_data),
    .out_valid (seq_out_valid),
    .out_ready (seq_out_ready),
    .out_data  (seq_out_data)
  );

  // ------------------------------
  // Data side
  // ------------------------------
  rd_mux_fsm i_fsm (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .seq_valid (seq_out_valid),
    .seq_ready (seq_out_ready),
    .seq_data  (seq_out_data),
    .last_beat (last_beat),
    .load      (load),
    .active    (active),
    .sel_vfid  (sel_vfid)
  );

  rd_beat_counter i_cnt (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .load      (load),
    .load_len  (seq_out_data.len),
    .beat_fire (beat_fire),
    .last_beat (last_beat)
  );

  rd_data_select i_sel (
    .active     (active),
    .sel_vfid   (sel_vfid),
    .rd_tvalid  (rd_tvalid),
    .rd_tready  (rd_tready),
    .rd_tdata   (rd_tdata),
    .rd_tlast   (rd_tlast),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tdata  (out_tdata),
    .out_tlast  (out_tlast),
    .beat_fire  (beat_fire)
  );

endmodule

`default_nettype wire

//--- verilog/rdma_rd_pkg.sv
// RDMA read mux shared definitions
// Sizes of the region, length, address and data fields, the request
// and sequence entry formats, and the beat count rule used to split
// a byte length into data beats

`default_nettype none

package rdma_rd_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int N_REGIONS       = 4;
  localparam int REGION_BITS     = 2;
  localparam int LEN_BITS        = 16;
  localparam int ADDR_BITS       = 32;
  localparam int DATA_BITS       = 64;
  // 8 bytes per beat
  localparam int BEAT_LOG_BITS   = 3;
  localparam int CNT_BITS        = LEN_BITS - BEAT_LOG_BITS + 1;
  // Queue depths
  localparam int N_OUTSTANDING   = 8;
  localparam int REQ_QUEUE_DEPTH = 4;

  // ------------------------------
  // Entry formats
  // ------------------------------
  // Read request as seen on the command port
  typedef struct packed {
    logic [REGION_BITS-1:0] vfid;
    logic                   host;
    logic [LEN_BITS-1:0]    len;
    logic [ADDR_BITS-1:0]   vaddr;
  } req_t;

  // In-order record of every accepted request
  typedef struct packed {
    logic [REGION_BITS-1:0] vfid;
    logic [LEN_BITS-1:0]    len;
  } seq_t;

  // Beats minus one, rounded up to whole beats
  // Length must be at least 1
  function automatic logic [CNT_BITS-1:0] beats_minus_one(input logic [LEN_BITS-1:0] len);
    logic [CNT_BITS-1:0] whole;
    whole = CNT_BITS'(len[LEN_BITS-1:BEAT_LOG_BITS]);
    // Partial tail beat adds one, which cancels the minus one
    if (len[BEAT_LOG_BITS-1:0] != '0) begin
      return whole;
    end
    return whole - 1'b1;
  endfunction

endpackage

`default_nettype wire
